// ==== rtl/tdc_cfg.svh ====
`ifndef TDC_CFG_SVH
`define TDC_CFG_SVH

// identifier in the top nibble of every word
`define TDC_DATA_ID 4'b0100

// coarse counter and timestamp counter width
`define TDC_COARSE_BITS 16

// multiphase fine time from outside the channel
`define TDC_FINE_BITS 2

// encoded delay line count
`define TDC_TDL_BITS 7

// thermometer snapshot length
`define TDC_TAPS 127

// word buffer depth
`define TDC_FIFO_DEPTH 16

// credits granted by the readout after reset
`define TDC_CREDITS 4

`endif

// ==== rtl/tdc_pkg.sv ====
`include "tdc_cfg.svh"

package tdc_pkg;

	// channel state encoding matches the readout firmware
	typedef enum logic [3:0] {
		IDLE      = 4'd0,
		IDLE_TRIG = 4'd1,
		TRIGGERED = 4'd2,
		RIS_EDGE  = 4'd3,
		FAL_EDGE  = 4'd4,
		FIFO_FULL = 4'd5,
		MISSED    = 4'd6,
		CALIB     = 4'd7,
		CALIB_HIT = 4'd8,
		RESET     = 4'd9
	} tdc_state_e;

	// word opcodes
	typedef enum logic [2:0] {
		TRIGGERED_WORD = 3'd0,
		RISING_WORD    = 3'd1,
		FALLING_WORD   = 3'd2,
		TIMESTAMP_WORD = 3'd3,
		CALIB_WORD     = 3'd4,
		MISS_WORD      = 3'd5,
		RESET_WORD     = 3'd6
	} word_type_e;

	// one time measurement
	typedef struct packed {
		logic [`TDC_COARSE_BITS-1:0] coarse;
		logic [`TDC_FINE_BITS-1:0]   fine;
		logic [`TDC_TDL_BITS-1:0]    tdl;
	} tdc_time_t;

	// 32-bit readout word
	typedef struct packed {
		logic [3:0]                  id;
		word_type_e                  wtype;
		logic [`TDC_COARSE_BITS-1:0] coarse;
		logic [`TDC_FINE_BITS-1:0]   fine;
		logic [`TDC_TDL_BITS-1:0]    tdl;
	} tdc_word_t;

endpackage

// ==== rtl/tdl_encoder.sv ====
`timescale 1ns/10ps
`include "tdc_cfg.svh"

module tdl_encoder (
	input  logic                     CLK,
	input  logic                     rst,
	input  logic [`TDC_TAPS-1:0]     tdl_snapshot,
	output logic [`TDC_TDL_BITS-1:0] tdl_time
);

	logic [`TDC_TAPS+1:0]     padded;
	logic [`TDC_TAPS-1:0]     corrected;
	logic [`TDC_TDL_BITS-1:0] count;

	// before the first tap reads as one, past the last as zero
	assign padded = {1'b0, tdl_snapshot, 1'b1};

	// three tap majority removes single bubbles
	always_comb begin
		for (int i = 0; i < `TDC_TAPS; i++) begin
			corrected[i] = (padded[i] & padded[i+1]) |
				(padded[i+1] & padded[i+2]) |
				(padded[i] & padded[i+2]);
		end
	end

	// length of the ones run starting at tap 0
	always_comb begin
		logic run;
		run = 1'b1;
		count = '0;
		for (int i = 0; i < `TDC_TAPS; i++) begin
			run = run & corrected[i];
			count = count + {{(`TDC_TDL_BITS-1){1'b0}}, run};
		end
	end

	// aligned with the controller sampling hit
	always_ff @(posedge CLK) begin
		if (rst) begin
			tdl_time <= '0;
		end else begin
			tdl_time <= count;
		end
	end

	// a full line must count exactly up to the last tap
	a_tdl_full_scale: assert property (
		@(posedge CLK) disable iff (rst)
		&tdl_snapshot |=> tdl_time == `TDC_TDL_BITS'(`TDC_TAPS)
	) else $error("full snapshot encoded as %0d", tdl_time);

endmodule

// ==== rtl/tdc_controller.sv ====
`timescale 1ns/10ps
`include "tdc_cfg.svh"

module tdc_controller (
	input  logic                        CLK,
	input  logic                        rst,
	input  logic                        trig,
	input  logic                        hit,
	input  logic                        calib_req,
	input  logic                        chan_reset,
	input  logic                        fifo_almost_full,
	output tdc_pkg::tdc_state_e         tdc_state,
	output logic [`TDC_COARSE_BITS-1:0] coarse_count,
	output logic [`TDC_COARSE_BITS-1:0] signal_timestamp,
	output logic [`TDC_COARSE_BITS-1:0] reset_timestamp
);

	tdc_pkg::tdc_state_e         state_next;
	logic                        hit_q;
	logic                        hit_rise;
	logic                        hit_fall;
	logic [`TDC_COARSE_BITS-1:0] ts_count;

	assign hit_rise = hit & ~hit_q;
	assign hit_fall = ~hit & hit_q;

	always_comb begin
		state_next = tdc_state;
		case (tdc_state)
			tdc_pkg::IDLE: begin
				if (chan_reset)
					state_next = tdc_pkg::RESET;
				else if (calib_req)
					state_next = tdc_pkg::CALIB;
				else if (hit_rise)
					state_next = fifo_almost_full ? tdc_pkg::FIFO_FULL : tdc_pkg::RIS_EDGE;
				else if (trig)
					state_next = tdc_pkg::IDLE_TRIG;
			end
			tdc_pkg::IDLE_TRIG: begin
				state_next = chan_reset ? tdc_pkg::RESET : tdc_pkg::TRIGGERED;
			end
			tdc_pkg::TRIGGERED: begin
				if (chan_reset)
					state_next = tdc_pkg::RESET;
				else if (hit_rise)
					state_next = fifo_almost_full ? tdc_pkg::FIFO_FULL : tdc_pkg::RIS_EDGE;
			end
			tdc_pkg::RIS_EDGE: begin
				if (chan_reset)
					state_next = tdc_pkg::RESET;
				else if (hit_fall)
					state_next = fifo_almost_full ? tdc_pkg::FIFO_FULL : tdc_pkg::FAL_EDGE;
			end
			tdc_pkg::FAL_EDGE: begin
				state_next = trig ? tdc_pkg::IDLE_TRIG : tdc_pkg::IDLE;
			end
			tdc_pkg::FIFO_FULL: state_next = tdc_pkg::MISSED;
			tdc_pkg::MISSED:    state_next = tdc_pkg::IDLE;
			tdc_pkg::CALIB: begin
				if (chan_reset)
					state_next = tdc_pkg::RESET;
				else if (hit_rise)
					state_next = tdc_pkg::CALIB_HIT;
				else if (!calib_req)
					state_next = tdc_pkg::IDLE;
			end
			tdc_pkg::CALIB_HIT: state_next = tdc_pkg::IDLE;
			tdc_pkg::RESET:     state_next = tdc_pkg::IDLE;
			default:            state_next = tdc_pkg::IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			tdc_state <= tdc_pkg::IDLE;
			hit_q <= 1'b0;
			coarse_count <= '0;
			ts_count <= '0;
		end else begin
			tdc_state <= state_next;
			hit_q <= hit;
			ts_count <= ts_count + 1'b1;
			// coarse restarts on a fresh trigger only
			if (tdc_state == tdc_pkg::IDLE && state_next == tdc_pkg::IDLE_TRIG)
				coarse_count <= '0;
			else
				coarse_count <= coarse_count + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (state_next == tdc_pkg::RIS_EDGE && tdc_state != tdc_pkg::RIS_EDGE)
			signal_timestamp <= ts_count;
		if (state_next == tdc_pkg::RESET)
			reset_timestamp <= ts_count;
	end

	// the missed edge leaves no timestamp behind
	a_full_then_missed: assert property (
		@(posedge CLK) disable iff (rst)
		tdc_state == tdc_pkg::FIFO_FULL |=>
			tdc_state == tdc_pkg::MISSED && $stable(signal_timestamp)
	) else $error("FIFO_FULL not followed by MISSED with the edge dropped");

endmodule

// ==== rtl/word_broker.sv ====
`timescale 1ns/10ps
`include "tdc_cfg.svh"

module word_broker (
	input  logic                        CLK,
	input  logic                        rst,
	input  tdc_pkg::tdc_state_e         tdc_state,
	input  logic [`TDC_COARSE_BITS-1:0] coarse_count,
	input  logic [`TDC_FINE_BITS-1:0]   fine_phase,
	input  logic [`TDC_TDL_BITS-1:0]    tdl_time,
	input  logic [`TDC_COARSE_BITS-1:0] signal_timestamp,
	input  logic [`TDC_COARSE_BITS-1:0] reset_timestamp,
	input  logic                        en_write_timestamp,
	output logic                        out_valid,
	output tdc_pkg::tdc_word_t          out_word
);

	tdc_pkg::tdc_state_e prev_state;
	tdc_pkg::tdc_time_t  meas;
	tdc_pkg::tdc_time_t  meas_sat;
	tdc_pkg::tdc_time_t  payload;
	tdc_pkg::word_type_e wtype;
	logic                emit;
	logic                overflow;

	assign overflow = coarse_count[`TDC_COARSE_BITS-1];
	assign meas = '{coarse: coarse_count, fine: fine_phase, tdl: tdl_time};

	// coarse and fine pinned high once the counter passes half range
	assign meas_sat = overflow ? '{coarse: '1, fine: '1, tdl: tdl_time} : meas;

	always_comb begin
		emit = 1'b0;
		wtype = tdc_pkg::TRIGGERED_WORD;
		payload = meas;
		case ({prev_state, tdc_state})
			{tdc_pkg::IDLE_TRIG, tdc_pkg::TRIGGERED}: begin
				emit = 1'b1;
				wtype = tdc_pkg::TRIGGERED_WORD;
			end
			{tdc_pkg::IDLE, tdc_pkg::RIS_EDGE},
			{tdc_pkg::TRIGGERED, tdc_pkg::RIS_EDGE}: begin
				emit = 1'b1;
				wtype = tdc_pkg::RISING_WORD;
				payload = meas_sat;
			end
			{tdc_pkg::RIS_EDGE, tdc_pkg::FAL_EDGE}: begin
				emit = 1'b1;
				wtype = tdc_pkg::FALLING_WORD;
				payload = meas_sat;
			end
			{tdc_pkg::FAL_EDGE, tdc_pkg::IDLE},
			{tdc_pkg::FAL_EDGE, tdc_pkg::IDLE_TRIG}: begin
				emit = en_write_timestamp;
				wtype = tdc_pkg::TIMESTAMP_WORD;
				payload = '{coarse: signal_timestamp, fine: '0, tdl: '0};
			end
			{tdc_pkg::MISSED, tdc_pkg::IDLE}: begin
				emit = 1'b1;
				wtype = tdc_pkg::MISS_WORD;
				payload = '0;
			end
			{tdc_pkg::RESET, tdc_pkg::IDLE}: begin
				emit = 1'b1;
				wtype = tdc_pkg::RESET_WORD;
				payload = '{coarse: reset_timestamp, fine: '0, tdl: '0};
			end
			{tdc_pkg::CALIB, tdc_pkg::CALIB_HIT}: begin
				emit = 1'b1;
				wtype = tdc_pkg::CALIB_WORD;
				payload = '{coarse: '0, fine: fine_phase, tdl: tdl_time};
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			prev_state <= tdc_pkg::IDLE;
			out_valid <= 1'b0;
		end else begin
			prev_state <= tdc_state;
			out_valid <= emit;
		end
	end

	always_ff @(posedge CLK) begin
		if (emit)
			out_word <= '{id: `TDC_DATA_ID, wtype: wtype, coarse: payload.coarse,
				fine: payload.fine, tdl: payload.tdl};
	end

endmodule

// ==== rtl/word_fifo.sv ====
`timescale 1ns/10ps
`include "tdc_cfg.svh"

module word_fifo (
	input  logic               CLK,
	input  logic               rst,
	input  logic               out_valid,
	input  tdc_pkg::tdc_word_t out_word,
	input  logic               credit_return,
	output logic               fifo_almost_full,
	output logic               word_valid,
	output tdc_pkg::tdc_word_t word
);

	localparam int PTR_W = $clog2(`TDC_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`TDC_FIFO_DEPTH + 1);
	localparam int CRD_W = $clog2(`TDC_CREDITS + 1);

	tdc_pkg::tdc_word_t mem [`TDC_FIFO_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic [CRD_W-1:0]   credits;
	logic               full;
	logic               wr_en;
	logic               send;

	assign full = count == CNT_W'(`TDC_FIFO_DEPTH);
	assign wr_en = out_valid & ~full;
	// one word per cycle, only with a credit in hand
	assign send = (count != '0) && (credits != '0);
	assign fifo_almost_full = count >= CNT_W'(`TDC_FIFO_DEPTH - 1);

	always_ff @(posedge CLK) begin
		if (wr_en)
			mem[wr_ptr] <= out_word;
		if (send)
			word <= mem[rd_ptr];
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= CRD_W'(`TDC_CREDITS);
			word_valid <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(`TDC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (send)
				rd_ptr <= (rd_ptr == PTR_W'(`TDC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(wr_en) - CNT_W'(send);
			// send and return together cancel out
			credits <= credits - CRD_W'(send) + CRD_W'(credit_return);
			word_valid <= send;
		end
	end

	a_no_write_full: assert property (
		@(posedge CLK) disable iff (rst)
		!(out_valid && full)
	) else $error("word written into full FIFO");

	a_credit_limit: assert property (
		@(posedge CLK) disable iff (rst)
		credits <= CRD_W'(`TDC_CREDITS)
	) else $error("credits %0d above grant", credits);

endmodule

// ==== rtl/tdc_channel.sv ====
`timescale 1ns/10ps
`include "tdc_cfg.svh"

module tdc_channel (
	input  logic                      CLK,
	input  logic                      rst,
	input  logic                      trig,
	input  logic                      hit,
	input  logic                      calib_req,
	input  logic                      chan_reset,
	input  logic                      en_write_timestamp,
	input  logic [`TDC_FINE_BITS-1:0] fine_phase,
	input  logic [`TDC_TAPS-1:0]      tdl_snapshot,
	input  logic                      credit_return,
	output logic                      word_valid,
	output tdc_pkg::tdc_word_t        word
);

	logic [`TDC_TDL_BITS-1:0]    tdl_time;
	tdc_pkg::tdc_state_e         tdc_state;
	logic [`TDC_COARSE_BITS-1:0] coarse_count;
	logic [`TDC_COARSE_BITS-1:0] signal_timestamp;
	logic [`TDC_COARSE_BITS-1:0] reset_timestamp;
	logic                        out_valid;
	tdc_pkg::tdc_word_t          out_word;
	logic                        fifo_almost_full;

	tdl_encoder tdl_encoder_inst (
		.CLK          (CLK),
		.rst          (rst),
		.tdl_snapshot (tdl_snapshot),
		.tdl_time     (tdl_time)
	);

	tdc_controller tdc_controller_inst (
		.CLK              (CLK),
		.rst              (rst),
		.trig             (trig),
		.hit              (hit),
		.calib_req        (calib_req),
		.chan_reset       (chan_reset),
		.fifo_almost_full (fifo_almost_full),
		.tdc_state        (tdc_state),
		.coarse_count     (coarse_count),
		.signal_timestamp (signal_timestamp),
		.reset_timestamp  (reset_timestamp)
	);

	word_broker word_broker_inst (
		.CLK                (CLK),
		.rst                (rst),
		.tdc_state          (tdc_state),
		.coarse_count       (coarse_count),
		.fine_phase         (fine_phase),
		.tdl_time           (tdl_time),
		.signal_timestamp   (signal_timestamp),
		.reset_timestamp    (reset_timestamp),
		.en_write_timestamp (en_write_timestamp),
		.out_valid          (out_valid),
		.out_word           (out_word)
	);

	word_fifo word_fifo_inst (
		.CLK              (CLK),
		.rst              (rst),
		.out_valid        (out_valid),
		.out_word         (out_word),
		.credit_return    (credit_return),
		.fifo_almost_full (fifo_almost_full),
		.word_valid       (word_valid),
		.word             (word)
	);

endmodule

// ==== tb/tdc_tb_model.svh ====
`ifndef TDC_TB_MODEL_SVH
`define TDC_TB_MODEL_SVH

// leading ones after three tap majority with a one assumed below tap 0
function automatic int thermo_count(logic [`TDC_TAPS-1:0] snap);
	logic [`TDC_TAPS+1:0] ext;
	int ones;
	int len;
	ext = {1'b0, snap, 1'b1};
	len = 0;
	for (int i = 0; i < `TDC_TAPS; i++) begin
		ones = int'(ext[i]) + int'(ext[i+1]) + int'(ext[i+2]);
		if (ones >= 2 && len == i)
			len = i + 1;
	end
	return len;
endfunction

// expected readout word for one event
function automatic tdc_pkg::tdc_word_t build_word(tdc_pkg::word_type_e t,
		logic [`TDC_COARSE_BITS-1:0] coarse, logic [`TDC_FINE_BITS-1:0] fine,
		logic [`TDC_TDL_BITS-1:0] tdl);
	tdc_pkg::tdc_word_t w;
	w.id = `TDC_DATA_ID;
	w.wtype = t;
	w.coarse = coarse;
	w.fine = fine;
	w.tdl = tdl;
	case (t)
		tdc_pkg::RISING_WORD, tdc_pkg::FALLING_WORD: begin
			// top bit set means the counter ran past half range
			if (coarse[`TDC_COARSE_BITS-1]) begin
				w.coarse = '1;
				w.fine = '1;
			end
		end
		tdc_pkg::TIMESTAMP_WORD, tdc_pkg::RESET_WORD: begin
			w.fine = '0;
			w.tdl = '0;
		end
		tdc_pkg::CALIB_WORD: w.coarse = '0;
		tdc_pkg::MISS_WORD: begin
			w.coarse = '0;
			w.fine = '0;
			w.tdl = '0;
		end
		default: ;
	endcase
	return w;
endfunction

task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
	if (expected !== actual) begin
		mismatch_count++;
		$display("Error %s: expected %h, actual %h", name, expected, actual);
	end
endtask

`endif

// ==== tb/tdc_channel_tb.sv ====
`timescale 1ns/10ps
`include "tdc_cfg.svh"

module tdc_channel_tb;

	localparam int PERIOD = 40;
	localparam int TRIG_RUNS = 4;
	localparam int FREE_RUNS = 4;
	localparam int FILL_PULSES = 9;
	localparam int OVF_WAIT = 33000;
	localparam int NUM_EVENTS = 2 * TRIG_RUNS + FREE_RUNS + 2 + 2 + FILL_PULSES + 2;
	localparam int WATCHDOG_CYCLES = NUM_EVENTS * 64 + OVF_WAIT + 2000;

	logic                      CLK;
	logic                      rst;
	logic                      trig;
	logic                      hit;
	logic                      calib_req;
	logic                      chan_reset;
	logic                      en_write_timestamp;
	logic [`TDC_FINE_BITS-1:0] fine_phase;
	logic [`TDC_TAPS-1:0]      tdl_snapshot;
	logic                      credit_return = 1'b0;
	logic                      word_valid;
	tdc_pkg::tdc_word_t        word;

	integer             seed = 32'hd92776a9;
	int                 cycle;
	int                 last_restart;
	int                 cur_tdl;
	int                 mismatch_count;
	int                 other_count;
	int                 compared;
	int                 credits;
	int                 held_returns;
	bit                 hold_credits;
	string              test_name;
	tdc_pkg::tdc_word_t exp_q[$];
	string              name_q[$];
	int                 return_q[$];

	`include "tdc_tb_model.svh"

	tdc_channel tdc_channel_inst (
		.CLK                (CLK),
		.rst                (rst),
		.trig               (trig),
		.hit                (hit),
		.calib_req          (calib_req),
		.chan_reset         (chan_reset),
		.en_write_timestamp (en_write_timestamp),
		.fine_phase         (fine_phase),
		.tdl_snapshot       (tdl_snapshot),
		.credit_return      (credit_return),
		.word_valid         (word_valid),
		.word               (word)
	);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// same count as the DUT timestamp counter
	always @(posedge CLK) begin
		if (rst)
			cycle <= 0;
		else
			cycle <= cycle + 1;
	end

	task automatic wait_cycles(int n);
		repeat (n) @(negedge CLK);
	endtask

	task automatic expect_word(tdc_pkg::word_type_e t, int coarse, int fine, int tdl);
		exp_q.push_back(build_word(t, `TDC_COARSE_BITS'(coarse), `TDC_FINE_BITS'(fine),
			`TDC_TDL_BITS'(tdl)));
		name_q.push_back(test_name);
	endtask

	// random run length, sometimes with a bubble in the middle
	task automatic new_sample();
		logic [`TDC_TAPS-1:0] snap;
		int len;
		len = int'($unsigned($random(seed)) % (`TDC_TAPS + 1));
		snap = '0;
		for (int i = 0; i < len; i++) begin
			snap[i] = 1'b1;
		end
		if (len > 4 && $unsigned($random(seed)) % 2 == 0)
			snap[len / 2] = 1'b0;
		tdl_snapshot = snap;
		fine_phase = `TDC_FINE_BITS'($random(seed));
		cur_tdl = thermo_count(snap);
	endtask

	task automatic pulse_trig();
		trig = 1'b1;
		// coarse reads zero right after the sampling edge
		last_restart = cycle + 1;
		expect_word(tdc_pkg::TRIGGERED_WORD, 1, fine_phase, cur_tdl);
		wait_cycles(1);
		trig = 1'b0;
		wait_cycles(4);
	endtask

	task automatic hit_pulse(int width);
		int rise_cycle;
		hit = 1'b1;
		rise_cycle = cycle;
		expect_word(tdc_pkg::RISING_WORD, cycle + 1 - last_restart, fine_phase, cur_tdl);
		wait_cycles(width);
		hit = 1'b0;
		expect_word(tdc_pkg::FALLING_WORD, cycle + 1 - last_restart, fine_phase, cur_tdl);
		if (en_write_timestamp)
			expect_word(tdc_pkg::TIMESTAMP_WORD, rise_cycle, 0, 0);
		wait_cycles(4);
	endtask

	task automatic run_calibration();
		calib_req = 1'b1;
		wait_cycles(2);
		hit = 1'b1;
		calib_req = 1'b0;
		expect_word(tdc_pkg::CALIB_WORD, 0, fine_phase, cur_tdl);
		wait_cycles(2);
		hit = 1'b0;
		wait_cycles(4);
	endtask

	task automatic pulse_chan_reset();
		chan_reset = 1'b1;
		expect_word(tdc_pkg::RESET_WORD, cycle, 0, 0);
		wait_cycles(1);
		chan_reset = 1'b0;
		wait_cycles(4);
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0 || credits != `TDC_CREDITS)
			wait_cycles(1);
	endtask

	// compare words, track credits, hand credits back
	always @(negedge CLK) begin
		tdc_pkg::tdc_word_t expected;
		string name;
		if (rst) begin
			credits = `TDC_CREDITS;
			credit_return = 1'b0;
		end else begin
			if (word_valid) begin
				if (credits == 0) begin
					other_count++;
					$display("word sent at cycle %0d with no credit left", cycle);
				end else begin
					credits--;
				end
				if (exp_q.size() == 0) begin
					other_count++;
					$display("unexpected word %h at cycle %0d", word, cycle);
				end else begin
					expected = exp_q.pop_front();
					name = name_q.pop_front();
					check_value(name, expected, word);
					compared++;
				end
				if (hold_credits)
					held_returns++;
				else
					return_q.push_back(cycle + 1 + int'($unsigned($random(seed)) % 4));
			end
			// a return counts from the word after the one it was driven beside
			if (credit_return)
				credits++;
			if (!hold_credits && held_returns > 0) begin
				return_q.push_back(cycle);
				held_returns--;
			end
			credit_return = 1'b0;
			if (return_q.size() != 0 && return_q[0] <= cycle) begin
				void'(return_q.pop_front());
				credit_return = 1'b1;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		trig = 1'b0;
		hit = 1'b0;
		calib_req = 1'b0;
		chan_reset = 1'b0;
		en_write_timestamp = 1'b0;
		fine_phase = '0;
		tdl_snapshot = '0;
		hold_credits = 1'b0;
		last_restart = 0;
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;

		test_name = "triggered";
		en_write_timestamp = 1'b1;
		for (int i = 0; i < TRIG_RUNS; i++) begin
			wait_cycles(2);
			new_sample();
			pulse_trig();
			wait_cycles(int'($unsigned($random(seed)) % 20));
			new_sample();
			hit_pulse(2 + int'($unsigned($random(seed)) % 4));
		end

		test_name = "untriggered";
		en_write_timestamp = 1'b0;
		for (int i = 0; i < FREE_RUNS; i++) begin
			new_sample();
			hit_pulse(2 + int'($unsigned($random(seed)) % 4));
			wait_cycles(2 + int'($unsigned($random(seed)) % 6));
		end

		test_name = "overflow";
		en_write_timestamp = 1'b1;
		new_sample();
		pulse_trig();
		wait_cycles(OVF_WAIT);
		new_sample();
		hit_pulse(3);

		test_name = "calibration";
		new_sample();
		run_calibration();
		test_name = "soft_reset";
		pulse_chan_reset();

		// fill the FIFO to one free slot, then one more hit
		test_name = "backpressure";
		en_write_timestamp = 1'b0;
		wait_drained();
		hold_credits = 1'b1;
		for (int i = 0; i < FILL_PULSES; i++) begin
			new_sample();
			hit_pulse(2);
		end
		pulse_chan_reset();
		new_sample();
		hit = 1'b1;
		expect_word(tdc_pkg::MISS_WORD, 0, 0, 0);
		wait_cycles(3);
		hit = 1'b0;
		wait_cycles(8);
		hold_credits = 1'b0;
		wait_drained();
		wait_cycles(20);

		$display("Summary: %0d words compared, %0d mismatches, %0d other errors",
			compared, mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+rtl
+incdir+tb
rtl/tdc_pkg.sv
rtl/tdl_encoder.sv
rtl/tdc_controller.sv
rtl/word_broker.sv
rtl/word_fifo.sv
rtl/tdc_channel.sv
tb/tdc_channel_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tdc_channel_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
FAIL_MSG   := Result: FAILED
PASS_MSG   := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
